//--- bench/clockGen.sv
module clockGen #(
  parameter int period      = 40,
  parameter int resetCycles = 16
) (
  output logic CTL,
  output logic reset
);

  initial begin
    CTL = 1'b0;
    forever #(period / 2) CTL = ~CTL;
  end

  // Release reset on a falling edge, like the other inputs
  initial begin
    reset = 1'b1;
    repeat (resetCycles) @(posedge CTL);
    @(negedge CTL);
    reset = 1'b0;
  end

endmodule

//--- bench/ctlBench.sv
`include "ctl_consts.svh"

module ctlBench;

  // Reset, the six sweeps and a short tail
  localparam int vectorCount  = 16 + 24 + 128 + 80 + 33 + 12 + 17 + 3;
  localparam int clockPeriod  = 40;
  localparam int watchdogTime = vectorCount * clockPeriod * 3 / 2;

  logic               CTL;
  logic               reset;
  ctlPkg::microWord   word;
  ctlPkg::boardIn     board;
  ctlPkg::ebusIn      ebus;
  ctlPkg::regControls regs;
  ctlPkg::ebusOut     bus;
  logic               loadPc;
  logic               specMtrCtl;
  logic               specCall;

  ctlPkg::dispField dispCodes [0:6] = '{`DISP_DRAM_A_RD, `DISP_RETURN, `DISP_NICOND,
    `DISP_MUL, `DISP_DIV, `DISP_NORM, `DISP_EA_MOD};
  ctlPkg::specField specCodes [0:14] = '{`SPEC_INH_CRY18, `SPEC_MQ_SHIFT, `SPEC_SCM_ALT,
    `SPEC_CLR_FPD, `SPEC_LOAD_PC, `SPEC_XCRY_AR0, `SPEC_GEN_CRY18, `SPEC_STACK_UPDATE,
    `SPEC_SBR_CALL, `SPEC_ARL_IND, `SPEC_MTR_CTL, `SPEC_FLAG_CTL, `SPEC_SAVE_FLAGS,
    `SPEC_SP_MEM_CYCLE, `SPEC_AD_LONG};
  ctlPkg::specField carrySpecs [0:4] = '{6'o00, `SPEC_XCRY_AR0, `SPEC_SAVE_FLAGS,
    `SPEC_GEN_CRY18, `SPEC_STACK_UPDATE};

  // Expected values from the board rules
  ctlPkg::magicField regCtlExp;
  ctlPkg::diagSel    diagExp;
  ctlPkg::readback   diagModel;
  logic              arlIndExp;
  logic              specCallExp;
  logic              mqClrExp;
  logic              mqmEnExp;
  logic              mqX;
  logic              mqY;
  logic              adLongExp;
  logic [1:0]        carryExp;
  logic              loadPcCause;
  logic              consoleCtl;
  logic              readExp;
  logic              loadCause;

  clockGen #(.period(clockPeriod)) clocks (.CTL(CTL), .reset(reset));

  ctlTop DUT (
    .CTL        (CTL),
    .reset      (reset),
    .word       (word),
    .board      (board),
    .ebus       (ebus),
    .regs       (regs),
    .bus        (bus),
    .loadPc     (loadPc),
    .specMtrCtl (specMtrCtl),
    .specCall   (specCall)
  );

  function automatic logic [6:0] dispExpected(ctlPkg::dispField d);
    logic [6:0] hot;
    hot = '0;
    for (int i = 0; i < 7; i++) begin
      hot[6 - i] = (d == dispCodes[i]);
    end
    return hot;
  endfunction

  function automatic logic [14:0] specExpected(ctlPkg::specField s);
    logic [14:0] hot;
    hot = '0;
    for (int i = 0; i < 15; i++) begin
      hot[14 - i] = (s == specCodes[i]);
    end
    return hot;
  endfunction

  function automatic logic [6:0] dispStrobes(ctlPkg::decodeFlags f);
    return {f.dispDramARd, f.dispReturn, f.dispNicond, f.dispMul, f.dispDiv, f.dispNorm,
            f.dispEaMod};
  endfunction

  function automatic logic [14:0] specStrobes(ctlPkg::decodeFlags f);
    return {f.specInhCry18, f.specMqShift, f.specScmAlt, f.specClrFpd, f.specLoadPc,
            f.specXcryAr0, f.specGenCry18, f.specStackUpdate, f.specSbrCall, f.specArlInd,
            f.specMtrCtl, f.specFlagCtl, f.specSaveFlags, f.specSpMemCycle, f.specAdLong};
  endfunction

  always_comb begin
    regCtlExp   = (board.condEn && word.cond[3:5] == 3'd7) ? word.magic : '0;
    arlIndExp   = board.memArlInd | (word.spec == `SPEC_ARL_IND) |
                  (board.condEn && word.cond[3:5] == 3'd6);
    specCallExp = board.sbrCall | (word.spec == `SPEC_SBR_CALL);
    mqClrExp    = word.magic[2] & arlIndExp;
    mqmEnExp    = word.mqBit | board.masterReset;
    mqX         = board.masterReset | regCtlExp[7] | mqClrExp;
    mqY         = mqClrExp | regCtlExp[8] | (word.spec == `SPEC_MQ_SHIFT) |
                  (word.disp == `DISP_MUL) | (word.disp == `DISP_DIV);
    adLongExp   = (word.disp == `DISP_MUL) | (word.disp == `DISP_DIV) |
                  (word.disp == `DISP_NORM) | (word.spec == `SPEC_AD_LONG) |
                  (word.spec == `SPEC_MQ_SHIFT);
    carryExp[1] = (word.adCarry ^ (board.ar0 & (word.spec == `SPEC_XCRY_AR0))) &
                  ~(board.pcPlus1Inh & (word.spec == `SPEC_SAVE_FLAGS));
    carryExp[0] = (word.spec == `SPEC_GEN_CRY18) |
                  ((word.spec == `SPEC_STACK_UPDATE) & board.shortStack);
    loadPcCause = !reset && board.piCycle && board.sbrCall &&
                  (word.spec == `SPEC_LOAD_PC || word.disp == `DISP_NICOND);
    consoleCtl  = ebus.ds[0] | ebus.ds[1];
    diagExp     = consoleCtl ? ebus.ds : word.magic[2:8];
    readExp     = diagExp[0] & (diagExp[1:3] == 3'b000) &
                  (consoleCtl ? ebus.diagStrobe : board.condDiagFunc);
    loadCause   = ebus.diagStrobe & ~ebus.ds[0] & (ebus.ds[1:3] == 3'b111) &
                  (ebus.ds[4:6] == 3'd6);
  end

  // Reference copy of the diagnostic control register
  always @(posedge CTL) begin
    if (reset) begin
      diagModel <= '0;
    end else if (loadCause) begin
      diagModel <= ebus.data;
    end
  end

  task automatic failRun(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic reportMismatch(input string name, input logic [31:0] got,
                                input logic [31:0] want);
    failRun($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, want));
  endtask

  dispCheck: assert property (@(posedge CTL) disable iff (reset)
    dispStrobes(DUT.flags) == dispExpected(word.disp))
    else reportMismatch("dispatch strobes", $sampled(dispStrobes(DUT.flags)),
                        $sampled(dispExpected(word.disp)));
  specCheck: assert property (@(posedge CTL) disable iff (reset)
    specStrobes(DUT.flags) == specExpected(word.spec))
    else reportMismatch("special strobes", $sampled(specStrobes(DUT.flags)),
                        $sampled(specExpected(word.spec)));
  adLongCheck: assert property (@(posedge CTL) disable iff (reset)
    regs.adLong == adLongExp)
    else reportMismatch("regs.adLong", $sampled(regs.adLong), $sampled(adLongExp));
  mqCheck: assert property (@(posedge CTL) disable iff (reset)
    {regs.mqmEn, regs.mqmSel[1], regs.mqmSel[0], regs.mqSel[1], regs.mqSel[0]} ==
    {mqmEnExp, mqmEnExp & mqX, mqmEnExp & mqY, ~mqmEnExp & mqX, ~mqmEnExp & mqY})
    else reportMismatch("regs.mqmEn/mqmSel/mqSel",
      $sampled({regs.mqmEn, regs.mqmSel[1], regs.mqmSel[0], regs.mqSel[1], regs.mqSel[0]}),
      $sampled({mqmEnExp, mqmEnExp & mqX, mqmEnExp & mqY, ~mqmEnExp & mqX, ~mqmEnExp & mqY}));
  carryCheck: assert property (@(posedge CTL) disable iff (reset)
    {regs.adxCry36, regs.genCry18} == carryExp)
    else reportMismatch("regs.adxCry36/genCry18", $sampled({regs.adxCry36, regs.genCry18}),
                        $sampled(carryExp));
  specCallCheck: assert property (@(posedge CTL) disable iff (reset)
    !arlIndExp |-> specCall == specCallExp)
    else reportMismatch("specCall", $sampled(specCall), $sampled(specCallExp));
  loadPcCheck: assert property (@(posedge CTL) disable iff (reset)
    loadPc == $past(loadPcCause))
    else reportMismatch("loadPc", $sampled(loadPc), $past(loadPcCause));
  mtrCheck: assert property (@(posedge CTL) disable iff (reset)
    specMtrCtl == $past(!reset && word.spec == `SPEC_MTR_CTL))
    else reportMismatch("specMtrCtl", $sampled(specMtrCtl),
                        $past(!reset && word.spec == `SPEC_MTR_CTL));
  resetCheck: assert property (@(posedge CTL)
    reset |=> !loadPc && !specMtrCtl && !bus.driving)
    else reportMismatch("loadPc/specMtrCtl/bus.driving",
                        $sampled({loadPc, specMtrCtl, bus.driving}), 0);
  diagCheck: assert property (@(posedge CTL) disable iff (reset)
    DUT.diag == diagExp)
    else reportMismatch("diag", $sampled(DUT.diag), $sampled(diagExp));
  drivingCheck: assert property (@(posedge CTL) disable iff (reset)
    bus.driving == readExp)
    else reportMismatch("bus.driving", $sampled(bus.driving), $sampled(readExp));
  quietCheck: assert property (@(posedge CTL) disable iff (reset)
    !bus.driving |-> bus.data == '0)
    else reportMismatch("bus.data", $sampled(bus.data), 0);
  parityCheck: assert property (@(posedge CTL) disable iff (reset)
    bus.parityOut == (board.arParOdd | bus.adToEbus))
    else reportMismatch("bus.parityOut", $sampled(bus.parityOut),
                        $sampled(board.arParOdd | bus.adToEbus));
  group7Check: assert property (@(posedge CTL) disable iff (reset)
    (readExp && diagExp[4:6] == 3'd7) |->
    {bus.data[24], bus.data[25], bus.data[27]} ==
    {word.spec == `SPEC_INH_CRY18, diagModel[24], diagModel[26]})
    else reportMismatch("bus.data group 7",
      $sampled({bus.data[24], bus.data[25], bus.data[27]}),
      $sampled({word.spec == `SPEC_INH_CRY18, diagModel[24], diagModel[26]}));

  task automatic nextCycle();
    @(negedge CTL);
  endtask

  task automatic runStrobeSweep();
    for (int i = 0; i < 7; i++) begin
      nextCycle();
      word.disp = dispCodes[i];
    end
    nextCycle();
    word = '0;
    for (int i = 0; i < 15; i++) begin
      nextCycle();
      word.spec = specCodes[i];
    end
    nextCycle();
    word = '0;
  endtask

  task automatic runMqSweep();
    logic [6:0] pick;
    for (int v = 0; v < 128; v++) begin
      pick = 7'(v);
      nextCycle();
      board.condEn    = 1'b1;
      word.cond       = 6'o07;
      word.mqBit      = pick[0];
      word.magic      = '0;
      word.magic[7]   = pick[1];
      word.magic[8]   = pick[2];
      word.magic[2]   = pick[3];
      board.memArlInd = pick[4];
      word.spec       = pick[5] ? `SPEC_MQ_SHIFT : 6'o00;
      word.disp       = pick[6] ? `DISP_MUL : 5'o00;
    end
  endtask

  task automatic runCarrySweep();
    logic [3:0] pick;
    for (int s = 0; s < 5; s++) begin
      for (int v = 0; v < 16; v++) begin
        pick = 4'(v);
        nextCycle();
        word             = '0;
        board            = '0;
        word.spec        = carrySpecs[s];
        word.adCarry     = pick[0];
        board.ar0        = pick[1];
        board.pcPlus1Inh = pick[2];
        board.shortStack = pick[3];
      end
    end
  endtask

  task automatic runLoadPcSweep();
    logic [4:0] pick;
    for (int v = 0; v < 32; v++) begin
      pick = 5'(v);
      nextCycle();
      board         = '0;
      board.piCycle = pick[0];
      board.sbrCall = pick[1];
      word.spec     = pick[3] ? (pick[2] ? `SPEC_LOAD_PC : `SPEC_MTR_CTL) :
                                (pick[2] ? `SPEC_LOAD_PC : 6'o00);
      word.disp     = pick[4] ? `DISP_NICOND : 5'o00;
    end
    nextCycle();
    word  = '0;
    board = '0;
  endtask

  // Console 076 load, then a 10x read of group 7, then an idle bus
  task automatic runDiagLoadRead();
    ctlPkg::readback values [0:3];
    values = '{5'b10100, 5'b00100, 5'b10000, 5'b01011};
    for (int k = 0; k < 4; k++) begin
      nextCycle();
      ebus.ds         = 7'b0111110;
      ebus.diagStrobe = 1'b1;
      ebus.data       = values[k];
      nextCycle();
      ebus.ds           = 7'b1000111;
      ebus.data         = '0;
      word.spec         = k[0] ? `SPEC_INH_CRY18 : 6'o00;
      board.conoOrDatao = k[1];
      nextCycle();
      ebus  = '0;
      word  = '0;
      board = '0;
    end
  endtask

  task automatic runMicroReadback();
    logic [2:0] group;
    board.condDiagFunc = 1'b1;
    for (int v = 0; v < 16; v++) begin
      group = 3'(v);
      nextCycle();
      word.magic     = {2'b00, 1'b1, 3'b000, group};
      word.spec      = v[3] ? `SPEC_INH_CRY18 : 6'o00;
      board.arParOdd = v[0];
    end
    nextCycle();
    board = '0;
  endtask

  initial begin
    #(watchdogTime);
    failRun("Watchdog expired before the stimulus finished");
  end

  initial begin
    word  = '0;
    board = '0;
    ebus  = '0;
    // Held during reset so that the registered strobes would rise without it
    word.disp     = `DISP_NICOND;
    word.spec     = `SPEC_MTR_CTL;
    board.piCycle = 1'b1;
    board.sbrCall = 1'b1;
    wait (reset === 1'b0);
    word  = '0;
    board = '0;
    runStrobeSweep();
    runMqSweep();
    runCarrySweep();
    runLoadPcSweep();
    runDiagLoadRead();
    runMicroReadback();
    repeat (3) nextCycle();
    $display("sim passed");
    $finish;
  end

endmodule

//--- include/ctl_consts.svh
`ifndef CTL_CONSTS_SVH
`define CTL_CONSTS_SVH

// Control-store field widths
`define CTL_DISP_W   5
`define CTL_SPEC_W   6
`define CTL_COND_W   6
`define CTL_MAGIC_W  9
`define CTL_DS_W     7
`define CTL_RDBK_W   5

// Dispatch field codes, octal as in the microcode listings
`define DISP_DRAM_A_RD  5'o02
`define DISP_RETURN     5'o03
`define DISP_NICOND     5'o06
`define DISP_MUL        5'o30
`define DISP_DIV        5'o31
`define DISP_NORM       5'o35
`define DISP_EA_MOD     5'o36

// Special function codes
`define SPEC_INH_CRY18     6'o11
`define SPEC_MQ_SHIFT      6'o12
`define SPEC_SCM_ALT       6'o13
`define SPEC_CLR_FPD       6'o14
`define SPEC_LOAD_PC       6'o15
`define SPEC_XCRY_AR0      6'o16
`define SPEC_GEN_CRY18     6'o17
`define SPEC_STACK_UPDATE  6'o20
`define SPEC_SBR_CALL      6'o21
`define SPEC_ARL_IND       6'o22
`define SPEC_MTR_CTL       6'o23
`define SPEC_FLAG_CTL      6'o24
`define SPEC_SAVE_FLAGS    6'o25
`define SPEC_SP_MEM_CYCLE  6'o26
`define SPEC_AD_LONG       6'o27

// Condition subfield, cond bits 3 to 5
`define COND_ARLL_LOAD  3'd1
`define COND_ARLR_LOAD  3'd2
`define COND_ARR_LOAD   3'd3
`define COND_AR_CLR     3'd4
`define COND_ARX_CLR    3'd5
`define COND_ARL_IND    3'd6
`define COND_REG_CTL    3'd7

// Diagnostic function groups
`define DIAG_LOAD_07X  3'b111
`define DIAG_LOAD_076  3'b110
`define DIAG_READ_10X  3'b000

`endif

//--- sim.f
+incdir+include
src/ctlPkg.sv
src/microDecode.sv
src/regSelect.sv
src/diagDecode.sv
src/diagRegs.sv
src/ctlTop.sv
bench/clockGen.sv
bench/ctlBench.sv

//--- src/ctlPkg.sv
`include "ctl_consts.svh"

package ctlPkg;

  typedef logic [0:`CTL_DISP_W-1]  dispField;
  typedef logic [0:`CTL_SPEC_W-1]  specField;
  typedef logic [0:`CTL_COND_W-1]  condField;
  typedef logic [0:`CTL_MAGIC_W-1] magicField;
  typedef logic [0:`CTL_DS_W-1]    diagSel;
  // Bus data lines 24 to 28
  typedef logic [24:24+`CTL_RDBK_W-1] readback;

  typedef struct packed {
    dispField   disp;
    specField   spec;
    condField   cond;
    magicField  magic;
    logic [0:2] arField;
    logic [0:2] arxField;
    logic       mqBit;
    logic       adCarry;
  } microWord;

  // Levels from the other boards
  typedef struct packed {
    logic condEn;
    logic piCycle;
    logic pcPlus1Inh;
    logic fmXfer;
    logic loadAr;
    logic loadArx;
    logic shortStack;
    logic memArlInd;
    logic ea18;
    logic ea23;
    logic arx18;
    logic ar0;
    logic respMbox;
    logic respSim;
    logic sbrCall;
    logic masterReset;
    logic conoOrDatao;
    logic coniOrDatai;
    logic condDiagFunc;
    logic gateTtlToEcl;
    logic ebusReturn;
    logic arParOdd;
  } boardIn;

  typedef struct packed {
    logic dispDramARd;
    logic dispReturn;
    logic dispNicond;
    logic dispMul;
    logic dispDiv;
    logic dispNorm;
    logic dispEaMod;
    logic specInhCry18;
    logic specMqShift;
    logic specScmAlt;
    logic specClrFpd;
    logic specLoadPc;
    logic specXcryAr0;
    logic specGenCry18;
    logic specStackUpdate;
    logic specSbrCall;
    logic specArlInd;
    logic specMtrCtl;
    logic specFlagCtl;
    logic specSaveFlags;
    logic specSpMemCycle;
    logic specAdLong;
    logic condArllLoad;
    logic condArlrLoad;
    logic condArrLoad;
    logic condArClr;
    logic condArxClr;
    logic condArlInd;
    logic condRegCtl;
  } decodeFlags;

  typedef struct packed {
    logic [0:2] arlSel;
    logic [0:1] arrSel;
    logic [0:1] arxlSel;
    logic [0:1] arxrSel;
    logic [0:1] mqSel;
    logic [0:1] mqmSel;
    logic       mqmEn;
    logic       ar00to08Load;
    logic       ar09to17Load;
    logic       arrLoad;
    logic       arxLoad;
    logic       ar00to11Clr;
    logic       ar12to17Clr;
    logic       arrClr;
    logic       arxClr;
    logic       mqClr;
    logic       arlInd;
    logic       adLong;
    logic       adxCry36;
    logic       genCry18;
    logic       inhCry18;
    magicField  regCtl;
  } regControls;

  typedef struct packed {
    diagSel  ds;
    logic    diagStrobe;
    readback data;
  } ebusIn;

  typedef struct packed {
    logic    driving;
    readback data;
    logic    parityOut;
    logic    adToEbus;
    logic    tToEEn;
    logic    eToTEn;
  } ebusOut;

endpackage

//--- src/ctlTop.sv
module ctlTop (
  input  logic               CTL,
  input  logic               reset,
  input  ctlPkg::microWord   word,
  input  ctlPkg::boardIn     board,
  input  ctlPkg::ebusIn      ebus,
  output ctlPkg::regControls regs,
  output ctlPkg::ebusOut     bus,
  output logic               loadPc,
  output logic               specMtrCtl,
  output logic               specCall
);

  ctlPkg::decodeFlags flags;
  ctlPkg::diagSel     diag;
  ctlPkg::ebusOut     busEnables;
  ctlPkg::ebusOut     readOut;
  logic               readFunc10x;
  logic               loadFunc076;
  logic               consoleControl;

  microDecode uDecode (
    .CTL        (CTL),
    .reset      (reset),
    .word       (word),
    .board      (board),
    .flags      (flags),
    .loadPc     (loadPc),
    .specMtrCtl (specMtrCtl)
  );

  regSelect uRegSel (
    .word     (word),
    .board    (board),
    .flags    (flags),
    .regs     (regs),
    .specCall (specCall)
  );

  diagDecode uDiagDec (
    .word           (word),
    .board          (board),
    .ebus           (ebus),
    .diag           (diag),
    .readFunc10x    (readFunc10x),
    .loadFunc076    (loadFunc076),
    .consoleControl (consoleControl),
    .busEnables     (busEnables)
  );

  diagRegs uDiagRegs (
    .CTL         (CTL),
    .reset       (reset),
    .ebus        (ebus),
    .flags       (flags),
    .regs        (regs),
    .diag        (diag),
    .readFunc10x (readFunc10x),
    .loadFunc076 (loadFunc076),
    .readOut     (readOut)
  );

  // Readback drives data, the decoder drives the transceiver enables
  always_comb begin
    bus.driving   = readOut.driving;
    bus.data      = readOut.data;
    bus.adToEbus  = busEnables.adToEbus;
    bus.parityOut = board.arParOdd | bus.adToEbus;
    bus.tToEEn    = busEnables.tToEEn;
    bus.eToTEn    = busEnables.eToTEn;
  end

endmodule

//--- src/diagDecode.sv
`include "ctl_consts.svh"

module diagDecode (
  input  ctlPkg::microWord word,
  input  ctlPkg::boardIn   board,
  input  ctlPkg::ebusIn    ebus,
  output ctlPkg::diagSel   diag,
  output logic             readFunc10x,
  output logic             loadFunc076,
  output logic             consoleControl,
  output ctlPkg::ebusOut   busEnables
);

  logic readStrobe;
  logic loadFunc07x;

  always_comb begin
    // Console owns the function when either top select bit is set
    consoleControl = ebus.ds[0] | ebus.ds[1];
    diag           = consoleControl ? ebus.ds : word.magic[2:8];
    readStrobe     = consoleControl ? ebus.diagStrobe : board.condDiagFunc;

    readFunc10x = diag[0] & readStrobe & (diag[1:3] == `DIAG_READ_10X);

    // Load functions come only from the console side
    loadFunc07x = ebus.diagStrobe & ~ebus.ds[0] & (ebus.ds[1:3] == `DIAG_LOAD_07X);
    loadFunc076 = loadFunc07x & (ebus.ds[4:6] == `DIAG_LOAD_076);
  end

  always_comb begin
    busEnables = '0;

    busEnables.adToEbus = consoleControl &
                          (board.conoOrDatao | board.condDiagFunc | word.magic[2]);

    // Transceiver directions
    busEnables.tToEEn = consoleControl &
                        (board.gateTtlToEcl | board.coniOrDatai | ebus.ds[0]);
    busEnables.eToTEn = (board.ebusReturn | consoleControl) & busEnables.tToEEn;
  end

endmodule

//--- src/diagRegs.sv
module diagRegs (
  input  logic               CTL,
  input  logic               reset,
  input  ctlPkg::ebusIn      ebus,
  input  ctlPkg::decodeFlags flags,
  input  ctlPkg::regControls regs,
  input  ctlPkg::diagSel     diag,
  input  logic               readFunc10x,
  input  logic               loadFunc076,
  output ctlPkg::ebusOut     readOut
);

  // 24 memReset, 25 chanClkStop, 26 ldEbusReg, 27 forceExtend, 28 selBit
  ctlPkg::readback diagCtl;

  always_ff @(posedge CTL) begin
    if (reset) begin
      diagCtl <= '0;
    end else if (loadFunc076) begin
      diagCtl <= ebus.data;
    end
  end

  always_comb begin
    readOut = '0;
    readOut.driving = readFunc10x;
    if (readFunc10x) begin
      unique case (diag[4:6])
        3'd0: readOut.data = {flags.specScmAlt, flags.specSaveFlags, regs.arlSel[1],
                              regs.arrLoad, regs.ar00to08Load};
        3'd1: readOut.data = {flags.specClrFpd, flags.specMtrCtl, regs.arlSel[0],
                              regs.arrLoad, regs.ar09to17Load};
        // regCtl bit 5 is the AR exponent condition
        3'd2: readOut.data = {flags.specGenCry18, regs.regCtl[5], regs.arrSel[1],
                              regs.mqmSel[1], regs.arxLoad};
        3'd3: readOut.data = {flags.specStackUpdate, flags.dispReturn, regs.arrSel[0],
                              regs.mqmSel[0], regs.arlSel[2]};
        3'd4: readOut.data = {flags.specFlagCtl, flags.specLoadPc, regs.arxlSel[1],
                              regs.mqSel[1], regs.ar00to11Clr};
        3'd5: readOut.data = {flags.specSpMemCycle, flags.specXcryAr0, regs.arxlSel[0],
                              regs.mqSel[0], regs.ar12to17Clr};
        3'd6: readOut.data = {regs.adLong, regs.adxCry36, regs.arxrSel[1],
                              regs.mqmEn, regs.arrClr};
        3'd7: readOut.data = {regs.inhCry18, diagCtl[24], regs.arxrSel[0],
                              diagCtl[26], flags.specSbrCall};
      endcase
    end
  end

  // Bus lines must stay quiet unless this board owns them
  quietBus: assert property (@(posedge CTL) disable iff (reset)
    !readOut.driving |-> (readOut.data == '0))
    else $error("Readback data active while not driving");

endmodule

//--- src/microDecode.sv
`include "ctl_consts.svh"

module microDecode (
  input  logic               CTL,
  input  logic               reset,
  input  ctlPkg::microWord   word,
  input  ctlPkg::boardIn     board,
  output ctlPkg::decodeFlags flags,
  output logic               loadPc,
  output logic               specMtrCtl
);

  logic loadPcEn;

  always_comb begin
    flags.dispDramARd = word.disp == `DISP_DRAM_A_RD;
    flags.dispReturn  = word.disp == `DISP_RETURN;
    flags.dispNicond  = word.disp == `DISP_NICOND;
    flags.dispMul     = word.disp == `DISP_MUL;
    flags.dispDiv     = word.disp == `DISP_DIV;
    flags.dispNorm    = word.disp == `DISP_NORM;
    flags.dispEaMod   = word.disp == `DISP_EA_MOD;

    flags.specInhCry18    = word.spec == `SPEC_INH_CRY18;
    flags.specMqShift     = word.spec == `SPEC_MQ_SHIFT;
    flags.specScmAlt      = word.spec == `SPEC_SCM_ALT;
    flags.specClrFpd      = word.spec == `SPEC_CLR_FPD;
    flags.specLoadPc      = word.spec == `SPEC_LOAD_PC;
    flags.specXcryAr0     = word.spec == `SPEC_XCRY_AR0;
    flags.specGenCry18    = word.spec == `SPEC_GEN_CRY18;
    flags.specStackUpdate = word.spec == `SPEC_STACK_UPDATE;
    flags.specSbrCall     = word.spec == `SPEC_SBR_CALL;
    flags.specArlInd      = word.spec == `SPEC_ARL_IND;
    flags.specMtrCtl      = word.spec == `SPEC_MTR_CTL;
    flags.specFlagCtl     = word.spec == `SPEC_FLAG_CTL;
    flags.specSaveFlags   = word.spec == `SPEC_SAVE_FLAGS;
    flags.specSpMemCycle  = word.spec == `SPEC_SP_MEM_CYCLE;
    flags.specAdLong      = word.spec == `SPEC_AD_LONG;

    // Condition subfield only counts while the condition enable is up
    flags.condArllLoad = board.condEn && (word.cond[3:5] == `COND_ARLL_LOAD);
    flags.condArlrLoad = board.condEn && (word.cond[3:5] == `COND_ARLR_LOAD);
    flags.condArrLoad  = board.condEn && (word.cond[3:5] == `COND_ARR_LOAD);
    flags.condArClr    = board.condEn && (word.cond[3:5] == `COND_AR_CLR);
    flags.condArxClr   = board.condEn && (word.cond[3:5] == `COND_ARX_CLR);
    flags.condArlInd   = board.condEn && (word.cond[3:5] == `COND_ARL_IND);
    flags.condRegCtl   = board.condEn && (word.cond[3:5] == `COND_REG_CTL);
  end

  // Load PC during a PI cycle on a subroutine call
  assign loadPcEn = board.piCycle & board.sbrCall & (flags.specLoadPc | flags.dispNicond);

  always_ff @(posedge CTL) begin
    if (reset) begin
      loadPc     <= 1'b0;
      specMtrCtl <= 1'b0;
    end else begin
      loadPc     <= loadPcEn;
      // Meter control reclocked one stage
      specMtrCtl <= flags.specMtrCtl;
    end
  end

  dispOneHot: assert property (@(posedge CTL) disable iff (reset)
    $onehot0({flags.dispDramARd, flags.dispReturn, flags.dispNicond, flags.dispMul,
              flags.dispDiv, flags.dispNorm, flags.dispEaMod}))
    else $error("More than one dispatch strobe active");

endmodule

//--- src/regSelect.sv
module regSelect (
  input  ctlPkg::microWord   word,
  input  ctlPkg::boardIn     board,
  input  ctlPkg::decodeFlags flags,
  output ctlPkg::regControls regs,
  output logic               specCall
);

  logic            arlInd;
  logic            indSel0;
  logic            indSel1;
  logic            arClr;
  logic            shortEa;
  logic            ea36;
  logic            fmArLoad;
  logic            fmArxLoad;
  logic            respAny;
  logic            leftLoad;
  logic            mqX;
  logic            mqY;
  ctlPkg::magicField regCtl;

  always_comb begin
    regCtl = word.magic & {$bits(regCtl){flags.condRegCtl}};
    arlInd = board.memArlInd | flags.specArlInd | flags.condArlInd;

    // Indirect AR left: magic bits stand in for the AR and clear fields
    regs.mqClr  = arlInd ? word.magic[2] : 1'b0;
    regs.arxClr = arlInd ? word.magic[3] : flags.condArxClr;
    arClr       = arlInd ? word.magic[4] : flags.condArClr;
    regs.arrClr = arlInd ? word.magic[5] : flags.condArClr;
    indSel1     = arlInd ? word.magic[7] : word.arField[1];
    indSel0     = arlInd ? word.magic[8] : word.arField[0];
    regs.arlSel[2] = arlInd ? word.magic[6] : word.arField[2];
    specCall    = board.sbrCall | (arlInd ? word.magic[0] : flags.specSbrCall);

    shortEa          = flags.dispEaMod & board.arx18;
    regs.ar12to17Clr = board.masterReset | board.ea18 | arClr | shortEa;
    regs.ar00to11Clr = regs.ar12to17Clr | board.ea23;

    // Full-word EA on a DRAM A read
    ea36      = flags.dispDramARd & regs.ar00to11Clr;
    fmArLoad  = board.fmXfer & board.loadAr;
    fmArxLoad = board.fmXfer & board.loadArx;
    respAny   = board.respMbox | board.respSim;

    regs.arlSel[1]  = indSel1 | ea36 | fmArLoad;
    regs.arlSel[0]  = indSel0 | (board.loadAr & respAny);
    regs.arrSel[1]  = word.arField[1] | flags.dispDramARd | fmArLoad;
    regs.arrSel[0]  = word.arField[2] | (board.loadAr & respAny);
    regs.arxlSel[1] = word.arxField[1] | fmArxLoad;
    regs.arxlSel[0] = word.arxField[2] | (board.loadArx & respAny);
    regs.arxrSel    = regs.arxlSel;

    leftLoad          = regs.ar00to11Clr | (|regs.arlSel);
    regs.ar09to17Load = flags.condArlrLoad | regCtl[1] | leftLoad;
    regs.ar00to08Load = flags.condArllLoad | regCtl[0] | leftLoad |
                        (word.magic[0] & arlInd);
    regs.arrLoad      = regCtl[2] | (|regs.arrSel) | regs.arrClr | flags.condArrLoad;
    regs.arxLoad      = word.arxField[0] | (|regs.arxrSel) | regs.arxClr |
                        board.masterReset;

    // MQ select, master reset forces the MQM path
    regs.mqmEn     = word.mqBit | board.masterReset;
    mqX            = board.masterReset | regCtl[7] | regs.mqClr;
    mqY            = regs.mqClr | regCtl[8] | flags.specMqShift | flags.dispMul |
                     flags.dispDiv;
    regs.mqmSel[1] = regs.mqmEn & mqX;
    regs.mqSel[1]  = ~regs.mqmEn & mqX;
    regs.mqmSel[0] = regs.mqmEn & mqY;
    regs.mqSel[0]  = ~regs.mqmEn & mqY;

    regs.adLong   = flags.dispMul | flags.dispDiv | flags.dispNorm | flags.specAdLong |
                    flags.specMqShift;
    regs.adxCry36 = (word.adCarry ^ (board.ar0 & flags.specXcryAr0)) &
                    ~(board.pcPlus1Inh & flags.specSaveFlags);
    regs.genCry18 = flags.specGenCry18 | (flags.specStackUpdate & board.shortStack);
    regs.inhCry18 = flags.specInhCry18;

    regs.arlInd = arlInd;
    regs.regCtl = regCtl;
  end

  // MQ input comes from one path at a time
  always_comb begin
    mqExclusive: assert final (!((|regs.mqmSel) && (|regs.mqSel)))
      else $error("MQM and MQ selects both active");
  end

endmodule
